// File: gf_pkg.sv
// GF(2^8) field constants, opcode enum, command/job/response structs
// and the Mastrovito reduction matrix for the field polynomial
package gf_pkg;

    localparam int gf_width = 8;
    localparam logic [gf_width:0] gf_poly = 9'h11D;

    typedef logic [gf_width-1:0] gf_elem_t;

    // x^254 is the inverse of any nonzero element
    localparam gf_elem_t gf_inv_exp = 8'd254;

    // row j: which of product bits 8..14 fold into result bit j
    function automatic logic [gf_width-1:0][gf_width-2:0] gf_build_red_matrix();
        logic [gf_width-1:0][gf_width-2:0] m;
        logic [gf_width:0] r;
        m = '0;
        // start from x^8 mod poly
        r = {1'b0, gf_poly[gf_width-1:0]};
        for (int i = 0; i < gf_width - 1; i++) begin
            for (int j = 0; j < gf_width; j++) begin
                m[j][i] = r[j];
            end
            r = {r[gf_width-1:0], 1'b0};
            if (r[gf_width]) begin
                r = r ^ gf_poly;
            end
        end
        return m;
    endfunction

    localparam logic [gf_width-1:0][gf_width-2:0] gf_red_matrix = gf_build_red_matrix();

    typedef enum logic [1:0] {
        op_mul = 2'd0,
        op_pow = 2'd1,
        op_inv = 2'd2
    } gf_op_t;

    typedef struct packed {
        gf_op_t   op;
        gf_elem_t a;
        gf_elem_t b;
    } gf_cmd_t;

    typedef struct packed {
        gf_elem_t acc;
        gf_elem_t base;
        gf_elem_t exponent;
    } gf_job_t;

    typedef struct packed {
        gf_elem_t data;
        logic     err;
    } gf_rsp_t;

endpackage

// File: gf_mult.sv
// combinational Mastrovito multiplier over GF(2^8)
// partial products followed by reduction through the fixed matrix
`timescale 1ns/100ps

module gf_mult
    import gf_pkg::*;
(
    input  gf_elem_t a,
    input  gf_elem_t b,
    output gf_elem_t p
);

    localparam int prod_width = 2 * gf_width - 1;

    // unreduced carry-less product
    logic [prod_width-1:0] d;
    // high half that has to be folded back
    logic [gf_width-2:0]   d_high;

    // partial-product stage
    always_comb begin
        d = '0;
        for (int i = 0; i < gf_width; i++) begin
            for (int j = 0; j < gf_width; j++) begin
                d[i+j] = d[i+j] ^ (a[i] & b[j]);
            end
        end
    end

    assign d_high = d[prod_width-1:gf_width];

    // reduction stage
    always_comb begin
        for (int j = 0; j < gf_width; j++) begin
            p[j] = d[j] ^ (^(d_high & gf_red_matrix[j]));
        end
    end

endmodule

// File: gf_decode.sv
// command decode: maps an accepted opcode to exponentiation job values
// or flags an immediate error
`timescale 1ns/100ps

module gf_decode
    import gf_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cmd_valid,
    input  gf_cmd_t cmd,
    input  logic    exec_busy,
    output logic    job_start,
    output gf_job_t job,
    output logic    err_start,
    output logic    pending
);

    logic    accept;
    logic    bad_cmd;
    gf_job_t next_job;

    // strobes while anything is in flight are dropped
    assign accept = cmd_valid && !pending && !exec_busy;

    always_comb begin
        next_job = '{acc: cmd.a, base: cmd.b, exponent: gf_elem_t'(1)};
        bad_cmd  = 1'b0;
        case (cmd.op)
            op_mul: next_job = '{acc: cmd.a, base: cmd.b, exponent: gf_elem_t'(1)};
            op_pow: next_job = '{acc: gf_elem_t'(1), base: cmd.a, exponent: cmd.b};
            op_inv: begin
                next_job = '{acc: gf_elem_t'(1), base: cmd.a, exponent: gf_inv_exp};
                // zero has no inverse
                bad_cmd  = (cmd.a == '0);
            end
            default: bad_cmd = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            job_start <= 1'b0;
            err_start <= 1'b0;
        end else begin
            job_start <= accept && !bad_cmd;
            err_start <= accept && bad_cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            job <= next_job;
        end
    end

    // covers the cycle between acceptance and exec picking up the job
    assign pending = job_start | err_start;

endmodule

// File: gf_exec.sv
// square-and-multiply engine sharing one Mastrovito multiplier
// between the multiply and square steps
`timescale 1ns/100ps

module gf_exec
    import gf_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     job_start,
    input  gf_job_t  job,
    output logic     busy,
    output logic     exec_done,
    output gf_elem_t exec_data
);

    gf_elem_t acc;
    gf_elem_t base;
    gf_elem_t exponent;
    // set after the multiply step so that the square follows
    logic     phase;
    logic     mul_step;
    gf_elem_t mul_a;
    gf_elem_t prod;

    // exponent bit set and not yet multiplied in
    assign mul_step  = !phase && exponent[0];
    assign exec_done = busy && (exponent == '0);
    assign exec_data = acc;

    // multiply and square both take the base as second operand
    assign mul_a = mul_step ? acc : base;

    gf_mult u_mult (
        .a (mul_a),
        .b (base),
        .p (prod)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            phase <= 1'b0;
        end else if (job_start) begin
            busy  <= 1'b1;
            phase <= 1'b0;
        end else if (exec_done) begin
            busy  <= 1'b0;
        end else if (busy) begin
            phase <= mul_step;
        end
    end

    always_ff @(posedge clk) begin
        if (job_start) begin
            acc      <= job.acc;
            base     <= job.base;
            exponent <= job.exponent;
        end else if (busy && !exec_done) begin
            if (mul_step) begin
                acc <= prod;
            end else begin
                base     <= prod;
                exponent <= exponent >> 1;
            end
        end
    end

endmodule

// File: gf_result.sv
// response register with one-cycle valid pulse and error flag
`timescale 1ns/100ps

module gf_result
    import gf_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     exec_done,
    input  gf_elem_t exec_data,
    input  logic     err_start,
    output logic     rsp_valid,
    output gf_rsp_t  rsp
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            rsp       <= '0;
        end else begin
            rsp_valid <= exec_done | err_start;
            if (exec_done) begin
                rsp <= '{data: exec_data, err: 1'b0};
            end else if (err_start) begin
                // error responses carry no data
                rsp <= '{data: '0, err: 1'b1};
            end
        end
    end

endmodule

// File: gf_unit.sv
// GF(2^8) arithmetic unit top: decode, square-and-multiply execute, response
`timescale 1ns/100ps

module gf_unit
    import gf_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cmd_valid,
    input  gf_cmd_t cmd,
    output logic    busy,
    output logic    rsp_valid,
    output gf_rsp_t rsp
);

    logic     job_start;
    gf_job_t  job;
    logic     err_start;
    logic     pending;
    logic     exec_busy;
    logic     exec_done;
    gf_elem_t exec_data;

    assign busy = pending | exec_busy;

    gf_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .exec_busy (exec_busy),
        .job_start (job_start),
        .job       (job),
        .err_start (err_start),
        .pending   (pending)
    );

    gf_exec u_exec (
        .clk       (clk),
        .rst_n     (rst_n),
        .job_start (job_start),
        .job       (job),
        .busy      (exec_busy),
        .exec_done (exec_done),
        .exec_data (exec_data)
    );

    gf_result u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .exec_done (exec_done),
        .exec_data (exec_data),
        .err_start (err_start),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

// File: gf_unit_tb.sv
// testbench for gf_unit: file-driven vectors, ignored strobe while busy,
// busy/response timing, watchdog and pass/fail summary
`timescale 1ns/100ps

module gf_unit_tb
    import gf_pkg::*;
();

    localparam int clk_half     = 4;
    localparam int rsp_wait_max = 40;
    localparam int quiet_cycles = 20;

    logic    clk;
    logic    rst_n;
    logic    cmd_valid;
    gf_cmd_t cmd;
    logic    busy;
    logic    rsp_valid;
    gf_rsp_t rsp;

    // vectors as read from the data file
    string      vec_name[$];
    logic [1:0] vec_op[$];
    gf_elem_t   vec_a[$];
    gf_elem_t   vec_b[$];
    gf_elem_t   vec_data[$];
    logic       vec_err[$];

    int pass_count      = 0;
    int fail_count      = 0;
    int check_errors    = 0;
    int watchdog_cycles = 0;

    gf_unit DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    // shift-and-add product, reducing after every shift
    function automatic gf_elem_t gf_mul_ref(gf_elem_t x, gf_elem_t y);
        logic [gf_width:0] x_sh;
        gf_elem_t          p;
        x_sh = {1'b0, x};
        p    = '0;
        for (int i = 0; i < gf_width; i++) begin
            if (y[i]) begin
                p = p ^ x_sh[gf_width-1:0];
            end
            x_sh = x_sh << 1;
            if (x_sh[gf_width]) begin
                x_sh = x_sh ^ gf_poly;
            end
        end
        return p;
    endfunction

    task automatic load_vectors(output logic ok);
        int    fd;
        int    rc;
        string line;
        string nm;
        int    op_i;
        int    a_i;
        int    b_i;
        int    d_i;
        int    e_i;
        ok = 1'b0;
        fd = $fopen("gf_unit_testdata.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                // skip comment lines
                if (rc > 0 && line.getc(0) != "#") begin
                    rc = $sscanf(line, "%s %h %h %h %h %h", nm, op_i, a_i, b_i, d_i, e_i);
                    if (rc == 6) begin
                        vec_name.push_back(nm);
                        vec_op.push_back(op_i[1:0]);
                        vec_a.push_back(a_i[7:0]);
                        vec_b.push_back(b_i[7:0]);
                        vec_data.push_back(d_i[7:0]);
                        vec_err.push_back(e_i[0]);
                    end
                end
            end
            $fclose(fd);
            ok = (vec_name.size() > 0);
        end
    endtask

    // called right after a falling edge; holds the strobe for one cycle
    task automatic issue_cmd(logic [1:0] op_val, gf_elem_t a_val, gf_elem_t b_val);
        cmd_valid = 1'b1;
        cmd       = '{op: gf_op_t'(op_val), a: a_val, b: b_val};
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    // returns at the falling edge inside the rsp_valid cycle
    task automatic wait_rsp(string name, output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < rsp_wait_max) begin
            if (rsp_valid) begin
                seen = 1'b1;
                assert (!busy) else begin
                    $display("%s: busy still high in the response cycle", name);
                    check_errors++;
                end
            end else begin
                assert (busy) else begin
                    $display("%s: busy dropped before the response arrived", name);
                    check_errors++;
                end
                @(negedge clk);
                n++;
            end
        end
        assert (seen) else begin
            $display("%s: no response within %0d cycles", name, rsp_wait_max);
            check_errors++;
        end
    endtask

    task automatic finish_test(string name, int errs_before);
        if (check_errors == errs_before) begin
            pass_count++;
            $display("test %s passed", name);
        end else begin
            fail_count++;
            $display("test %s failed", name);
        end
    endtask

    task automatic check_reset_state();
        int errs_before;
        errs_before = check_errors;
        assert (!busy) else begin
            $display("mismatch reset_state busy: expected 0, actual %b", busy);
            check_errors++;
        end
        assert (!rsp_valid) else begin
            $display("mismatch reset_state rsp_valid: expected 0, actual %b", rsp_valid);
            check_errors++;
        end
        assert (rsp == '0) else begin
            $display("mismatch reset_state rsp: expected 000, actual %h", rsp);
            check_errors++;
        end
        finish_test("reset_state", errs_before);
    endtask

    task automatic run_vector(int idx);
        string    name;
        gf_elem_t a;
        gf_elem_t exp_data;
        logic     exp_err;
        logic     seen;
        int       errs_before;
        name        = vec_name[idx];
        a           = vec_a[idx];
        exp_data    = vec_data[idx];
        exp_err     = vec_err[idx];
        errs_before = check_errors;
        issue_cmd(vec_op[idx], a, vec_b[idx]);
        assert (busy) else begin
            $display("%s: command was not accepted, busy low afterwards", name);
            check_errors++;
        end
        wait_rsp(name, seen);
        if (seen) begin
            assert (rsp.data == exp_data) else begin
                $display("mismatch %s data: expected %h, actual %h", name, exp_data, rsp.data);
                check_errors++;
            end
            assert (rsp.err == exp_err) else begin
                $display("mismatch %s err: expected %b, actual %b", name, exp_err, rsp.err);
                check_errors++;
            end
            // a times its inverse must be one
            if (vec_op[idx] == op_inv && !exp_err) begin
                assert (gf_mul_ref(a, rsp.data) == 8'h01) else begin
                    $display("mismatch %s a*inv: expected 01, actual %h",
                             name, gf_mul_ref(a, rsp.data));
                    check_errors++;
                end
            end
        end
        finish_test(name, errs_before);
    endtask

    task automatic check_busy_strobe();
        logic seen;
        int   errs_before;
        int   extra;
        errs_before = check_errors;
        // x^8 reduces to x^4 + x^3 + x^2 + 1
        issue_cmd(op_pow, 8'h02, 8'h08);
        assert (busy) else begin
            $display("busy_strobe: busy low, the second strobe would not overlap");
            check_errors++;
        end
        // strobe across pending and the exponent loop
        cmd_valid = 1'b1;
        cmd       = '{op: op_mul, a: 8'h05, b: 8'h07};
        repeat (2) @(negedge clk);
        cmd_valid = 1'b0;
        wait_rsp("busy_strobe", seen);
        if (seen) begin
            assert (rsp.data == 8'h1d && !rsp.err) else begin
                $display("mismatch busy_strobe rsp: expected 1d/0, actual %h/%b",
                         rsp.data, rsp.err);
                check_errors++;
            end
        end
        extra = 0;
        repeat (quiet_cycles) begin
            @(negedge clk);
            if (rsp_valid) begin
                extra++;
            end
        end
        assert (extra == 0) else begin
            $display("mismatch busy_strobe extra responses: expected 0, actual %0d", extra);
            check_errors++;
        end
        finish_test("busy_strobe", errs_before);
    endtask

    initial begin
        logic load_ok;
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        load_vectors(load_ok);
        if (load_ok) begin
            watchdog_cycles = (vec_name.size() + 3) * rsp_wait_max;
            repeat (5) @(negedge clk);
            rst_n = 1'b1;
            @(negedge clk);
            check_reset_state();
            // each vector is issued in the response cycle of the previous one
            for (int i = 0; i < vec_name.size(); i++) begin
                run_vector(i);
            end
            check_busy_strobe();
        end else begin
            $display("could not read any vectors from gf_unit_testdata.txt");
            fail_count++;
        end
        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // limit scales with the number of vectors
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: gf_unit_testdata.txt
# columns: name, opcode (0 mul, 1 pow, 2 inv, 3 illegal), a, b, expected data, expected err
# values in hex over the field polynomial 0x11D; b is unused for inv
mul_by_zero   0 00 57 00 0
mul_by_one    0 01 a7 a7 0
mul_reduce    0 80 02 1d 0
mul_small     0 02 02 04 0
mul_square3   0 03 03 05 0
mul_alpha9    0 1d 02 3a 0
mul_high      0 80 80 13 0
mul_all_ones  0 ff ff e2 0
mul_mixed     0 57 13 e0 0
mul_zero_left 0 00 ff 00 0
pow_zero_exp  1 02 00 01 0
pow_zero_zero 1 00 00 01 0
pow_one       1 05 01 05 0
pow_square    1 03 02 05 0
pow_alpha8    1 02 08 1d 0
pow_alpha14   1 02 0e 13 0
pow_order     1 02 ff 01 0
pow_sq_1d     1 1d 02 4c 0
pow_of_zero   1 00 05 00 0
inv_one       2 01 00 01 0
inv_alpha     2 02 00 8e 0
inv_8e        2 8e 00 02 0
inv_1d        2 1d 00 83 0
inv_03        2 03 00 f4 0
inv_80        2 80 00 1b 0
inv_zero      2 00 00 00 1
op_illegal    3 12 34 00 1
op_illegal_0  3 00 00 00 1

// File: gf_unit.f
gf_pkg.sv
gf_mult.sv
gf_decode.sv
gf_exec.sv
gf_result.sv
gf_unit.sv
gf_unit_tb.sv

// File: Makefile
# Verilator build and run of the GF(2^8) unit testbench

TOP       ?= gf_unit_tb
FILELIST  ?= gf_unit.f
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# pass only if the pass message appears in the simulation output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
